// ==== source/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

    localparam int NUM_BANKS       = 2;
    localparam int WORDS_PER_LINE  = 4;
    localparam int LINES_PER_BANK  = 16;
    localparam int WORD_BYTES      = 4;
    localparam int WORD_BITS       = 8 * WORD_BYTES;
    localparam int LINE_BYTES      = WORD_BYTES * WORDS_PER_LINE;
    localparam int WORD_ADDR_WIDTH = 16;
    localparam int LINE_ADDR_WIDTH = 14;
    localparam int CORE_TAG_WIDTH  = 8;

    // Word address fields, low to high
    localparam int OFFSET_BITS = 2;
    localparam int BANK_BITS   = 1;
    localparam int INDEX_BITS  = 4;
    localparam int TAG_BITS    = 9;

    typedef logic [WORD_BITS-1:0]       word_t;
    typedef logic [8*LINE_BYTES-1:0]    line_t;
    typedef logic [WORD_ADDR_WIDTH-1:0] word_addr_t;
    typedef logic [LINE_ADDR_WIDTH-1:0] line_addr_t;
    typedef logic [CORE_TAG_WIDTH-1:0]  core_tag_t;
    typedef logic [BANK_BITS-1:0]       bank_idx_t;
    typedef logic [LINE_BYTES-1:0]      line_byteen_t;
    typedef logic [OFFSET_BITS-1:0]     offset_t;
    typedef logic [INDEX_BITS-1:0]      index_t;
    typedef logic [TAG_BITS-1:0]        addr_tag_t;

    typedef enum logic [2:0] {
        IDLE,
        FILL_REQ,
        FILL_WAIT,
        RESPOND,
        WRITE_REQ
    } bank_state_e;

    function automatic line_addr_t word_line_addr(word_addr_t addr);
        return addr[WORD_ADDR_WIDTH-1:OFFSET_BITS];
    endfunction

    function automatic offset_t word_offset(word_addr_t addr);
        return addr[OFFSET_BITS-1:0];
    endfunction

    function automatic bank_idx_t addr_bank(line_addr_t addr);
        return addr[BANK_BITS-1:0];
    endfunction

    function automatic index_t addr_index(line_addr_t addr);
        return addr[BANK_BITS +: INDEX_BITS];
    endfunction

    function automatic addr_tag_t addr_tag(line_addr_t addr);
        return addr[LINE_ADDR_WIDTH-1 -: TAG_BITS];
    endfunction

    // First requester at or after the pointer
    function automatic bank_idx_t rr_pick(logic [NUM_BANKS-1:0] valid, bank_idx_t ptr);
        bank_idx_t pick;
        pick = ptr;
        for (int k = NUM_BANKS - 1; k >= 0; k--) begin
            if (valid[bank_idx_t'(ptr + k)]) begin
                pick = bank_idx_t'(ptr + k);
            end
        end
        return pick;
    endfunction

endpackage

`default_nettype wire

// ==== source/cache_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface bank_req_if;
    import cache_pkg::*;

    logic       valid;
    logic       rw;
    word_addr_t addr;
    word_t      data;
    core_tag_t  tag;
    logic       ready;

    modport source (output valid, rw, addr, data, tag, input ready);
    modport sink   (input valid, rw, addr, data, tag, output ready);
endinterface

interface bank_rsp_if;
    import cache_pkg::*;

    logic      valid;
    word_t     data;
    core_tag_t tag;
    logic      ready;

    modport source (output valid, data, tag, input ready);
    modport sink   (input valid, data, tag, output ready);
endinterface

interface dram_req_if;
    import cache_pkg::*;

    logic         valid;
    logic         rw;
    line_addr_t   addr;
    line_t        data;
    line_byteen_t byteen;
    logic         ready;

    modport source (output valid, rw, addr, data, byteen, input ready);
    modport sink   (input valid, rw, addr, data, byteen, output ready);
endinterface

`default_nettype wire

// ==== source/cache_bank_sel.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_bank_sel (
    input  wire                              core_req_valid,
    input  wire                              core_req_rw,
    input  wire cache_pkg::word_addr_t       core_req_addr,
    input  wire cache_pkg::word_t            core_req_data,
    input  wire cache_pkg::core_tag_t        core_req_tag,
    output logic                             core_req_ready,
    input  wire                              dram_rsp_valid,
    input  wire cache_pkg::line_addr_t       dram_rsp_addr,
    output logic [cache_pkg::NUM_BANKS-1:0]  fill_valid,
    bank_req_if.source                       bank_req [cache_pkg::NUM_BANKS]
);
    import cache_pkg::*;

    bank_idx_t            req_bank;
    bank_idx_t            fill_bank;
    logic [NUM_BANKS-1:0] bank_ready;

    assign req_bank  = addr_bank(word_line_addr(core_req_addr));
    assign fill_bank = addr_bank(dram_rsp_addr);

    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        assign bank_req[i].valid = core_req_valid && (req_bank == bank_idx_t'(i));
        assign bank_req[i].rw    = core_req_rw;
        assign bank_req[i].addr  = core_req_addr;
        assign bank_req[i].data  = core_req_data;
        assign bank_req[i].tag   = core_req_tag;
        assign bank_ready[i]     = bank_req[i].ready;

        // Fill goes to the bank that owns the line
        assign fill_valid[i] = dram_rsp_valid && (fill_bank == bank_idx_t'(i));
    end

    assign core_req_ready = bank_ready[req_bank];

endmodule

`default_nettype wire

// ==== source/cache_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_bank (
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        fill_valid,
    input  wire cache_pkg::line_addr_t fill_addr,
    input  wire cache_pkg::line_t      fill_data,
    bank_req_if.sink                   core_req,
    bank_rsp_if.source                 core_rsp,
    dram_req_if.source                 dram_req
);
    import cache_pkg::*;

    bank_state_e state;

    addr_tag_t                 tag_mem  [LINES_PER_BANK];
    line_t                     data_mem [LINES_PER_BANK];
    logic [LINES_PER_BANK-1:0] valid_mem;

    // Accepted request
    word_addr_t req_addr;
    word_t      req_data;
    core_tag_t  req_tag;
    word_t      rsp_data;

    line_addr_t in_line;
    index_t     in_idx;
    offset_t    in_off;
    logic       in_hit;
    logic       accept;

    line_addr_t req_line;
    index_t     req_idx;
    offset_t    req_off;
    logic       fill_match;

    assign in_line = word_line_addr(core_req.addr);
    assign in_idx  = addr_index(in_line);
    assign in_off  = word_offset(core_req.addr);
    assign in_hit  = valid_mem[in_idx] && (tag_mem[in_idx] == addr_tag(in_line));
    assign accept  = core_req.valid && core_req.ready;

    assign req_line = word_line_addr(req_addr);
    assign req_idx  = addr_index(req_line);
    assign req_off  = word_offset(req_addr);

    // Only the fill for our own outstanding line counts
    assign fill_match = (state == FILL_WAIT) && fill_valid && (fill_addr == req_line);

    assign core_req.ready = (state == IDLE);

    assign core_rsp.valid = (state == RESPOND);
    assign core_rsp.data  = rsp_data;
    assign core_rsp.tag   = req_tag;

    assign dram_req.valid = (state == FILL_REQ) || (state == WRITE_REQ);
    assign dram_req.rw    = (state == WRITE_REQ);
    assign dram_req.addr  = req_line;
    assign dram_req.data  = line_t'(req_data) << (req_off * WORD_BITS);

    // Write covers one word slot, fill needs no enables
    assign dram_req.byteen = (state == WRITE_REQ)
                           ? line_byteen_t'({WORD_BYTES{1'b1}}) << (req_off * WORD_BYTES)
                           : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= IDLE;
            valid_mem <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        if (core_req.rw) begin
                            state <= WRITE_REQ;
                        end else if (in_hit) begin
                            state <= RESPOND;
                        end else begin
                            state <= FILL_REQ;
                        end
                    end
                end
                FILL_REQ: begin
                    if (dram_req.ready) begin
                        state <= FILL_WAIT;
                    end
                end
                FILL_WAIT: begin
                    if (fill_match) begin
                        state              <= RESPOND;
                        valid_mem[req_idx] <= 1'b1;
                    end
                end
                RESPOND: begin
                    if (core_rsp.ready) begin
                        state <= IDLE;
                    end
                end
                WRITE_REQ: begin
                    if (dram_req.ready) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr <= core_req.addr;
            req_data <= core_req.data;
            req_tag  <= core_req.tag;
            rsp_data <= data_mem[in_idx][in_off*WORD_BITS +: WORD_BITS];
            // Write-through, update only on hit
            if (core_req.rw && in_hit) begin
                data_mem[in_idx][in_off*WORD_BITS +: WORD_BITS] <= core_req.data;
            end
        end
        if (fill_match) begin
            data_mem[req_idx] <= fill_data;
            tag_mem[req_idx]  <= addr_tag(req_line);
            rsp_data          <= fill_data[req_off*WORD_BITS +: WORD_BITS];
        end
    end

endmodule

`default_nettype wire

// ==== source/cache_dram_arb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_dram_arb (
    input  wire                      clk,
    input  wire                      reset,
    output logic                     dram_req_valid,
    output logic                     dram_req_rw,
    output cache_pkg::line_addr_t    dram_req_addr,
    output cache_pkg::line_byteen_t  dram_req_byteen,
    output cache_pkg::line_t         dram_req_data,
    input  wire                      dram_req_ready,
    dram_req_if.sink                 bank_dram [cache_pkg::NUM_BANKS]
);
    import cache_pkg::*;

    logic [NUM_BANKS-1:0] bank_valid;
    logic [NUM_BANKS-1:0] bank_rw;
    line_addr_t           bank_addr   [NUM_BANKS];
    line_byteen_t         bank_byteen [NUM_BANKS];
    line_t                bank_data   [NUM_BANKS];

    bank_idx_t rr_ptr;
    logic      grant_hold;
    bank_idx_t held_idx;
    bank_idx_t grant;

    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        assign bank_valid[i]  = bank_dram[i].valid;
        assign bank_rw[i]     = bank_dram[i].rw;
        assign bank_addr[i]   = bank_dram[i].addr;
        assign bank_byteen[i] = bank_dram[i].byteen;
        assign bank_data[i]   = bank_dram[i].data;
        assign bank_dram[i].ready = dram_req_ready && bank_valid[i]
                                  && (grant == bank_idx_t'(i));
    end

    // Stalled request keeps its grant
    assign grant = grant_hold ? held_idx : rr_pick(bank_valid, rr_ptr);

    assign dram_req_valid  = bank_valid[grant];
    assign dram_req_rw     = bank_rw[grant];
    assign dram_req_addr   = bank_addr[grant];
    assign dram_req_byteen = bank_byteen[grant];
    assign dram_req_data   = bank_data[grant];

    always_ff @(posedge clk) begin
        if (reset) begin
            rr_ptr     <= '0;
            grant_hold <= 1'b0;
            held_idx   <= '0;
        end else if (dram_req_valid) begin
            if (dram_req_ready) begin
                rr_ptr     <= bank_idx_t'(grant + 1);
                grant_hold <= 1'b0;
            end else begin
                grant_hold <= 1'b1;
                held_idx   <= grant;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/cache_rsp_arb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_rsp_arb (
    input  wire                    clk,
    input  wire                    reset,
    output logic                   core_rsp_valid,
    output cache_pkg::word_t       core_rsp_data,
    output cache_pkg::core_tag_t   core_rsp_tag,
    input  wire                    core_rsp_ready,
    bank_rsp_if.sink               bank_rsp [cache_pkg::NUM_BANKS]
);
    import cache_pkg::*;

    logic [NUM_BANKS-1:0] bank_valid;
    word_t                bank_data [NUM_BANKS];
    core_tag_t            bank_tag  [NUM_BANKS];

    bank_idx_t rr_ptr;
    logic      grant_hold;
    bank_idx_t held_idx;
    bank_idx_t grant;

    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        assign bank_valid[i] = bank_rsp[i].valid;
        assign bank_data[i]  = bank_rsp[i].data;
        assign bank_tag[i]   = bank_rsp[i].tag;
        assign bank_rsp[i].ready = core_rsp_ready && bank_valid[i]
                                 && (grant == bank_idx_t'(i));
    end

    assign grant = grant_hold ? held_idx : rr_pick(bank_valid, rr_ptr);

    assign core_rsp_valid = bank_valid[grant];
    assign core_rsp_data  = bank_data[grant];
    assign core_rsp_tag   = bank_tag[grant];

    always_ff @(posedge clk) begin
        if (reset) begin
            rr_ptr     <= '0;
            grant_hold <= 1'b0;
            held_idx   <= '0;
        end else if (core_rsp_valid) begin
            if (core_rsp_ready) begin
                rr_ptr     <= bank_idx_t'(grant + 1);
                grant_hold <= 1'b0;
            end else begin
                grant_hold <= 1'b1;
                held_idx   <= grant;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/cache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_top (
    input  wire                         clk,
    input  wire                         reset,

    input  wire                         core_req_valid,
    input  wire                         core_req_rw,
    input  wire cache_pkg::word_addr_t  core_req_addr,
    input  wire cache_pkg::word_t       core_req_data,
    input  wire cache_pkg::core_tag_t   core_req_tag,
    output logic                        core_req_ready,

    output logic                        core_rsp_valid,
    output cache_pkg::word_t            core_rsp_data,
    output cache_pkg::core_tag_t        core_rsp_tag,
    input  wire                         core_rsp_ready,

    output logic                        dram_req_valid,
    output logic                        dram_req_rw,
    output cache_pkg::line_addr_t       dram_req_addr,
    output cache_pkg::line_byteen_t     dram_req_byteen,
    output cache_pkg::line_t            dram_req_data,
    input  wire                         dram_req_ready,

    input  wire                         dram_rsp_valid,
    input  wire cache_pkg::line_addr_t  dram_rsp_addr,
    input  wire cache_pkg::line_t       dram_rsp_data
);
    import cache_pkg::*;

    logic [NUM_BANKS-1:0] fill_valid;

    bank_req_if bank_req  [NUM_BANKS] ();
    bank_rsp_if bank_rsp  [NUM_BANKS] ();
    dram_req_if bank_dram [NUM_BANKS] ();

    cache_bank_sel i_bank_sel (
        .core_req_valid (core_req_valid),
        .core_req_rw    (core_req_rw),
        .core_req_addr  (core_req_addr),
        .core_req_data  (core_req_data),
        .core_req_tag   (core_req_tag),
        .core_req_ready (core_req_ready),
        .dram_rsp_valid (dram_rsp_valid),
        .dram_rsp_addr  (dram_rsp_addr),
        .fill_valid     (fill_valid),
        .bank_req       (bank_req)
    );

    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        cache_bank i_bank (
            .clk        (clk),
            .reset      (reset),
            .fill_valid (fill_valid[i]),
            .fill_addr  (dram_rsp_addr),
            .fill_data  (dram_rsp_data),
            .core_req   (bank_req[i]),
            .core_rsp   (bank_rsp[i]),
            .dram_req   (bank_dram[i])
        );
    end

    cache_dram_arb i_dram_arb (
        .clk             (clk),
        .reset           (reset),
        .dram_req_valid  (dram_req_valid),
        .dram_req_rw     (dram_req_rw),
        .dram_req_addr   (dram_req_addr),
        .dram_req_byteen (dram_req_byteen),
        .dram_req_data   (dram_req_data),
        .dram_req_ready  (dram_req_ready),
        .bank_dram       (bank_dram)
    );

    cache_rsp_arb i_rsp_arb (
        .clk            (clk),
        .reset          (reset),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp_data  (core_rsp_data),
        .core_rsp_tag   (core_rsp_tag),
        .core_rsp_ready (core_rsp_ready),
        .bank_rsp       (bank_rsp)
    );

endmodule

`default_nettype wire

// ==== bench/cache_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_assertions (
    input wire                          clk,
    input wire                          reset,
    input wire                          core_rsp_valid,
    input wire                          core_rsp_ready,
    input wire cache_pkg::word_t        core_rsp_data,
    input wire cache_pkg::core_tag_t    core_rsp_tag,
    input wire                          dram_req_valid,
    input wire                          dram_req_ready,
    input wire                          dram_req_rw,
    input wire cache_pkg::line_addr_t   dram_req_addr,
    input wire cache_pkg::line_byteen_t dram_req_byteen,
    input wire cache_pkg::line_t        dram_req_data
);

    // Stalled response keeps its fields
    assert property (@(posedge clk) disable iff (reset)
        core_rsp_valid && !core_rsp_ready |=> core_rsp_valid
            && $stable(core_rsp_data) && $stable(core_rsp_tag))
        else $error("core response changed while waiting for ready");

    assert property (@(posedge clk) disable iff (reset)
        dram_req_valid && !dram_req_ready |=> dram_req_valid && $stable(dram_req_rw)
            && $stable(dram_req_addr) && $stable(dram_req_byteen) && $stable(dram_req_data))
        else $error("DRAM request changed while waiting for ready");

    // First cycle out of reset
    assert property (@(posedge clk) $past(reset) && !reset |-> !core_rsp_valid && !dram_req_valid)
        else $error("valid raised in the first cycle after reset");

endmodule

`default_nettype wire

// ==== bench/cache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_tb;
    import cache_pkg::*;

    localparam logic [31:0] SEED = 32'hdc5808a8;
    localparam int TIMEOUT    = 200;
    localparam int NUM_RANDOM = 200;

    typedef struct packed {
        core_tag_t   tag;
        word_t       data;
        logic [31:0] cyc;
    } rsp_rec_t;

    logic         clk = 1'b0;
    logic         reset = 1'b1;
    logic         core_req_valid = 1'b0;
    logic         core_req_rw = 1'b0;
    word_addr_t   core_req_addr = '0;
    word_t        core_req_data = '0;
    core_tag_t    core_req_tag = '0;
    logic         core_req_ready;
    logic         core_rsp_valid;
    word_t        core_rsp_data;
    core_tag_t    core_rsp_tag;
    logic         core_rsp_ready = 1'b0;
    logic         dram_req_valid;
    logic         dram_req_rw;
    line_addr_t   dram_req_addr;
    line_byteen_t dram_req_byteen;
    line_t        dram_req_data;
    logic         dram_req_ready = 1'b0;
    logic         dram_rsp_valid = 1'b0;
    line_addr_t   dram_rsp_addr = '0;
    line_t        dram_rsp_data = '0;

    // DRAM contents and the word view the checks expect
    line_t line_mem [1 << LINE_ADDR_WIDTH];
    word_t ref_mem  [1 << WORD_ADDR_WIDTH];

    line_addr_t rd_q  [$];
    int         due_q [$];
    rsp_rec_t   rsp_q [$];

    int           cyc = 0;
    int           acc_cyc = 0;
    int           checks = 0;
    int           errors = 0;
    int           dram_reads = 0;
    int           dram_writes = 0;
    line_addr_t   last_rd_addr = '0;
    line_addr_t   last_wr_addr = '0;
    line_byteen_t last_wr_byteen = '0;
    line_t        last_wr_data = '0;
    logic         rsp_stall = 1'b0;
    logic [31:0]  dram_rng;
    logic [31:0]  rsp_rng;
    logic [31:0]  test_rng;

    cache_top i_dut (.*);

    bind cache_top cache_assertions i_assertions (
        .clk             (clk),
        .reset           (reset),
        .core_rsp_valid  (core_rsp_valid),
        .core_rsp_ready  (core_rsp_ready),
        .core_rsp_data   (core_rsp_data),
        .core_rsp_tag    (core_rsp_tag),
        .dram_req_valid  (dram_req_valid),
        .dram_req_ready  (dram_req_ready),
        .dram_req_rw     (dram_req_rw),
        .dram_req_addr   (dram_req_addr),
        .dram_req_byteen (dram_req_byteen),
        .dram_req_data   (dram_req_data)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // DRAM model with random accept pattern and delayed fills
    always begin
        @(negedge clk);
        dram_rng = next_random(dram_rng);
        dram_req_ready = (dram_rng[1:0] != 2'b00);
        if (rd_q.size() != 0 && due_q[0] <= cyc) begin
            dram_rsp_valid = 1'b1;
            dram_rsp_addr  = rd_q.pop_front();
            dram_rsp_data  = line_mem[dram_rsp_addr];
            void'(due_q.pop_front());
        end else begin
            dram_rsp_valid = 1'b0;
        end
        #1;
        if (!reset && dram_req_valid && dram_req_ready) begin
            if (dram_req_rw) begin
                for (int b = 0; b < LINE_BYTES; b++) begin
                    if (dram_req_byteen[b]) begin
                        line_mem[dram_req_addr][b*8 +: 8] = dram_req_data[b*8 +: 8];
                    end
                end
                last_wr_addr   = dram_req_addr;
                last_wr_byteen = dram_req_byteen;
                last_wr_data   = dram_req_data;
                dram_writes++;
            end else begin
                rd_q.push_back(dram_req_addr);
                due_q.push_back(cyc + 2 + int'(dram_rng[3:2]));
                last_rd_addr = dram_req_addr;
                dram_reads++;
            end
        end
    end

    // Core response side records every transfer
    always begin
        @(negedge clk);
        rsp_rng = next_random(rsp_rng);
        core_rsp_ready = !rsp_stall || (rsp_rng[1:0] != 2'b00);
        #1;
        if (!reset && core_rsp_valid && core_rsp_ready) begin
            rsp_q.push_back({core_rsp_tag, core_rsp_data, 32'(cyc)});
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("error: %s expected %h got %h", name, exp, got);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("%s", what);
        end
    endtask

    task automatic send_req(input logic rw, input word_addr_t addr, input word_t data,
                            input core_tag_t tag);
        int t;
        t = 0;
        @(negedge clk);
        core_req_valid = 1'b1;
        core_req_rw    = rw;
        core_req_addr  = addr;
        core_req_data  = data;
        core_req_tag   = tag;
        #1;
        while (!core_req_ready && t < TIMEOUT) begin
            @(negedge clk);
            #1;
            t++;
        end
        check_true(core_req_ready, "timeout waiting for the cache to accept a request");
        acc_cyc = cyc;
        @(negedge clk);
        core_req_valid = 1'b0;
    endtask

    task automatic get_rsp(output rsp_rec_t rec);
        int t;
        t = 0;
        rec = '0;
        while (rsp_q.size() == 0 && t < TIMEOUT) begin
            @(posedge clk);
            t++;
        end
        check_true(rsp_q.size() != 0, "timeout waiting for a core response");
        if (rsp_q.size() != 0) begin
            rec = rsp_q.pop_front();
        end
    endtask

    task automatic expect_read(input word_addr_t addr, input core_tag_t tag, output int latency);
        rsp_rec_t rec;
        send_req(1'b0, addr, '0, tag);
        get_rsp(rec);
        check_value("core_rsp_tag", 32'(rec.tag), 32'(tag));
        check_value("core_rsp_data", rec.data, ref_mem[addr]);
        latency = int'(rec.cyc) - acc_cyc;
    endtask

    task automatic test_reset_state();
        @(negedge clk);
        #1;
        check_value("core_req_ready", 32'(core_req_ready), 32'd1);
        check_value("core_rsp_valid", 32'(core_rsp_valid), 32'd0);
        check_value("dram_req_valid", 32'(dram_req_valid), 32'd0);
    endtask

    task automatic test_read_miss_hit();
        word_addr_t addr;
        int         reads;
        int         latency;
        addr  = 16'h0123;
        reads = dram_reads;
        expect_read(addr, 8'h11, latency);
        check_value("dram read count", dram_reads, reads + 1);
        check_value("dram_req_addr", 32'(last_rd_addr), 32'(addr[15:2]));
        // Same word again from the bank
        reads = dram_reads;
        expect_read(addr, 8'h12, latency);
        check_value("dram read count", dram_reads, reads);
        check_value("hit latency", latency, 1);
    endtask

    task automatic test_writes();
        word_addr_t   addrs [2];
        line_byteen_t byteens [2];
        word_t        wdata;
        int           writes;
        int           t;
        int           latency;
        addrs[0] = 16'h0123;
        addrs[1] = 16'h3456;
        // Slots 3 and 2 of their lines
        byteens[0] = 16'hf000;
        byteens[1] = 16'h0f00;
        for (int i = 0; i < 2; i++) begin
            test_rng = next_random(test_rng);
            wdata    = test_rng;
            writes   = dram_writes;
            send_req(1'b1, addrs[i], wdata, 8'h20);
            t = 0;
            while (dram_writes == writes && t < TIMEOUT) begin
                @(posedge clk);
                t++;
            end
            check_true(dram_writes == writes + 1, "timeout waiting for the DRAM write");
            check_value("dram_req_addr", 32'(last_wr_addr), 32'(addrs[i][15:2]));
            check_value("dram_req_byteen", 32'(last_wr_byteen), 32'(byteens[i]));
            check_value("dram_req_data", last_wr_data[addrs[i][1:0]*32 +: 32], wdata);
            ref_mem[addrs[i]] = wdata;
        end
        expect_read(16'h0123, 8'h21, latency);
        expect_read(16'h3456, 8'h22, latency);
        // Neighbour slot of the missed line stays intact
        expect_read(16'h3457, 8'h23, latency);
    endtask

    task automatic test_random_reads();
        word_t      exp_data [256];
        logic       seen [256];
        rsp_rec_t   rec;
        word_addr_t addr;
        core_tag_t  tag;
        int         t;
        rsp_stall = 1'b1;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            test_rng = next_random(test_rng);
            // Narrow range gives hits, misses and conflicts
            addr = word_addr_t'(test_rng[9:0]);
            tag  = core_tag_t'(i);
            exp_data[tag] = ref_mem[addr];
            seen[tag] = 1'b0;
            send_req(1'b0, addr, '0, tag);
        end
        t = 0;
        while (rsp_q.size() < NUM_RANDOM && t < TIMEOUT) begin
            @(posedge clk);
            t++;
        end
        @(negedge clk);
        #2;
        check_true(!core_rsp_valid, "a core response is still pending after the last read");
        check_value("core response count", rsp_q.size(), NUM_RANDOM);
        while (rsp_q.size() != 0) begin
            rec = rsp_q.pop_front();
            check_true(int'(rec.tag) < NUM_RANDOM && !seen[rec.tag],
                       "core response with an unknown or repeated tag");
            if (int'(rec.tag) < NUM_RANDOM) begin
                check_value("core_rsp_data", rec.data, exp_data[rec.tag]);
                seen[rec.tag] = 1'b1;
            end
        end
        rsp_stall = 1'b0;
    endtask

    initial begin
        word_addr_t  wa;
        logic [31:0] rng;
        rng = SEED;
        for (int a = 0; a < (1 << WORD_ADDR_WIDTH); a++) begin
            wa  = word_addr_t'(a);
            rng = next_random(rng);
            line_mem[wa[15:2]][wa[1:0]*32 +: 32] = rng ^ {16'h0, wa};
            ref_mem[wa] = line_mem[wa[15:2]][wa[1:0]*32 +: 32];
        end
        dram_rng = rng;
        rsp_rng  = ~rng;
        test_rng = {rng[15:0], rng[31:16]};
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        test_reset_state();
        test_read_miss_hit();
        test_writes();
        test_random_reads();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
source/cache_pkg.sv
source/cache_if.sv
source/cache_bank_sel.sv
source/cache_bank.sv
source/cache_dram_arb.sv
source/cache_rsp_arb.sv
source/cache_top.sv
bench/cache_assertions.sv
bench/cache_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module cache_tb -f compile.f -o cache_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/cache_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^TESTS PASSED$"; then
    exit 0
fi
exit 1
